// ==== Makefile ====
# Verilator build and run for the text overlay renderer

VERILATOR ?= verilator
TOP       ?= tb_text_renderer
FILELIST  ?= text_renderer.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test completed successfully

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_text_renderer.sv ====
// Testbench for the text overlay renderer, checks every output pixel against a font model
`default_nettype none
`timescale 1ns/10ps

module tb_text_renderer;

    import text_pkg::*;

    typedef struct packed {
        logic visible;
        color_t color;
    } pixel_out_t;

    localparam int CYCLE_LIMIT = 100000;
    localparam int RANDOM_PIXELS = 300;
    localparam int WAIT_LIMIT = 64;

    logic pixel_clk = 1'b0;
    logic rst_n;
    logic frame_start;
    pixel_pos_t pixel;
    text_cfg_t cfg_in;
    logic text_pixel_visible;
    color_t text_pixel_color_332;

    text_cfg_t shadow_cfg;            // Model copy of the frame settings
    pixel_out_t exp_stage;            // Model of the locate stage
    pixel_out_t exp_out;              // Expected DUT output
    logic checks_on = 1'b0;
    integer seed;
    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;

    text_renderer uut (
        .pixel_clk            (pixel_clk),
        .rst_n                (rst_n),
        .pixel                (pixel),
        .frame_start          (frame_start),
        .cfg_in               (cfg_in),
        .text_pixel_visible   (text_pixel_visible),
        .text_pixel_color_332 (text_pixel_color_332)
    );

    always #5 pixel_clk = ~pixel_clk;

    function automatic pixel_out_t expected_output(input pixel_pos_t p, input text_cfg_t c);
        int rel_x;
        int rel_y;
        int len;
        glyph_bitmap_t bmp;
        pixel_out_t e;
        rel_x = int'(p.x) - int'(c.x_pos);
        rel_y = int'(p.y) - int'(c.y_pos);
        len = int'(message_length(c.id));
        e = '0;
        if (c.enable && p.display_enable && rel_x >= 0 && rel_y >= 0 &&
                rel_x < len * CHAR_WIDTH && rel_y < CHAR_HEIGHT) begin
            bmp = glyph_bitmap(message_glyph(c.id, char_idx_t'(rel_x / CHAR_WIDTH)));
            if (bmp[127 - rel_y * CHAR_WIDTH - rel_x % CHAR_WIDTH]) begin
                e.visible = 1'b1;
                e.color = c.color;
            end
        end
        return e;
    endfunction

    function automatic text_cfg_t make_cfg(input logic en, input text_id_t id, input int x,
                                           input int y, input color_t color);
        text_cfg_t c;
        c.enable = en;
        c.id = id;
        c.x_pos = coord_t'(x);
        c.y_pos = coord_t'(y);
        c.color = color;
        return c;
    endfunction

    // Reference pipeline, sees the same sampled inputs as the DUT
    always @(posedge pixel_clk) begin
        checks_on <= 1'b1;
        if (!rst_n) begin
            shadow_cfg <= '0;
            exp_stage <= '0;
            exp_out <= '0;
        end else begin
            exp_stage <= expected_output(pixel, shadow_cfg);
            exp_out <= exp_stage;
            if (frame_start) begin
                shadow_cfg <= cfg_in;
            end
        end
    end

    always @(negedge pixel_clk) begin
        if (checks_on) begin
            check_count++;
        end
    end

    visible_matches: assert property (@(negedge pixel_clk)
            !checks_on || text_pixel_visible == exp_out.visible)
        else begin
            $display("CHECK FAILED time=%0t signal=text_pixel_visible expected=%0b actual=%0b",
                     $time, exp_out.visible, text_pixel_visible);
            error_count++;
        end

    color_matches: assert property (@(negedge pixel_clk)
            !checks_on || text_pixel_color_332 == exp_out.color)
        else begin
            $display("CHECK FAILED time=%0t signal=text_pixel_color_332 expected=%h actual=%h",
                     $time, exp_out.color, text_pixel_color_332);
            error_count++;
        end

    task automatic drive_pixel(input int x, input int y, input logic de);
        @(posedge pixel_clk);
        pixel <= '{display_enable: de, x: coord_t'(x), y: coord_t'(y)};
    endtask

    task automatic load_config(input text_cfg_t c);
        @(posedge pixel_clk);
        cfg_in <= c;
        frame_start <= 1'b1;
        @(posedge pixel_clk);
        frame_start <= 1'b0;
    endtask

    task automatic sweep_area(input int x0, input int y0, input int w, input int h,
                              input logic de);
        for (int y = y0; y < y0 + h; y++) begin
            for (int x = x0; x < x0 + w && x < 1024; x++) begin
                drive_pixel(x, y, de);
            end
        end
    endtask

    task automatic settle_pipeline();
        repeat (3) drive_pixel(0, 0, 1'b0);    // Two stages plus one spare
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("[%0t] %s: passed", $time, name);
        end else begin
            tests_failed++;
            $display("[%0t] %s: failed with %0d errors", $time, name,
                     error_count - errors_before);
        end
    endtask

    initial begin
        repeat (CYCLE_LIMIT) @(posedge pixel_clk);
        $display("Simulation did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        int errs;
        int w;
        int px;
        int py;
        logic seen;
        text_cfg_t c;
        seed = 77;
        rst_n = 1'b0;
        frame_start = 1'b0;
        pixel = '0;
        cfg_in = '0;
        repeat (10) @(posedge pixel_clk);
        rst_n <= 1'b1;

        errs = error_count;
        settle_pipeline();
        report_test("reset", errs);

        errs = error_count;
        load_config(make_cfg(1'b1, TEXT_START, 100, 200, 8'hE0));
        sweep_area(98, 198, 5 * CHAR_WIDTH + 4, CHAR_HEIGHT + 4, 1'b1);
        settle_pipeline();
        report_test("START sweep", errs);

        errs = error_count;
        load_config(make_cfg(1'b1, TEXT_PRESS_BUTTON, 880, 50, 8'h1C));
        sweep_area(878, 48, 11 * CHAR_WIDTH + 4, CHAR_HEIGHT + 4, 1'b1);
        settle_pipeline();
        report_test("PRESS START sweep", errs);

        errs = error_count;
        for (int id = 0; id < 16; id++) begin
            c = make_cfg(1'b1, text_id_t'(id), int'($unsigned($random(seed)) % 900),
                         int'($unsigned($random(seed)) % 760), color_t'($random(seed)));
            load_config(c);
            w = int'(message_length(c.id)) * CHAR_WIDTH + 8;    // Box plus a margin
            for (int n = 0; n < RANDOM_PIXELS; n++) begin
                px = int'(c.x_pos) - 4 + int'($unsigned($random(seed)) % w);
                py = int'(c.y_pos) - 2 + int'($unsigned($random(seed)) % 20);
                drive_pixel(px, py, 1'b1);
            end
        end
        settle_pipeline();
        report_test("all message ids", errs);

        errs = error_count;
        load_config(make_cfg(1'b0, TEXT_START, 400, 400, 8'hFF));
        sweep_area(400, 400, 5 * CHAR_WIDTH, CHAR_HEIGHT, 1'b1);
        load_config(make_cfg(1'b1, TEXT_START, 400, 400, 8'hFF));
        sweep_area(400, 400, 5 * CHAR_WIDTH, CHAR_HEIGHT, 1'b0);   // Blanking interval
        settle_pipeline();
        report_test("enables", errs);

        errs = error_count;
        load_config(make_cfg(1'b1, TEXT_START, 100, 200, 8'hE0));
        @(posedge pixel_clk);
        cfg_in <= make_cfg(1'b1, TEXT_MENU, 300, 300, 8'h03);     // No frame_start yet
        sweep_area(100, 200, 5 * CHAR_WIDTH, CHAR_HEIGHT, 1'b1);
        sweep_area(300, 300, 4 * CHAR_WIDTH, CHAR_HEIGHT, 1'b1);
        load_config(make_cfg(1'b1, TEXT_MENU, 300, 300, 8'h03));
        seen = 1'b0;
        for (int i = 0; i < WAIT_LIMIT && !seen; i++) begin
            drive_pixel(300 + i, 302, 1'b1);
            @(negedge pixel_clk);
            seen = text_pixel_visible;
        end
        if (!seen) begin
            $display("No visible pixel within %0d cycles after the new settings were loaded",
                     WAIT_LIMIT);
            error_count++;
        end
        sweep_area(298, 298, 4 * CHAR_WIDTH + 4, CHAR_HEIGHT + 4, 1'b1);
        settle_pipeline();
        report_test("shadow config", errs);

        $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== text_cfg_regs.sv ====
// Text overlay config shadow registers that change only at frame start
`default_nettype none
`timescale 1ns/10ps

module text_cfg_regs (
    input  wire logic             pixel_clk,
    input  wire logic             rst_n,
    input  wire logic             frame_start,
    input  wire text_pkg::text_cfg_t cfg_in,
    output text_pkg::text_cfg_t   cfg
);

    import text_pkg::*;

    logic enable_q;
    coord_t x_pos_q;
    coord_t y_pos_q;
    color_t color_q;
    text_id_t id_q;

    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            enable_q <= 1'b0;                 // Overlay off until first frame load
        end else if (frame_start) begin
            enable_q <= cfg_in.enable;
        end
    end

    always_ff @(posedge pixel_clk) begin
        if (frame_start) begin
            x_pos_q <= cfg_in.x_pos;
            y_pos_q <= cfg_in.y_pos;
            color_q <= cfg_in.color;
            id_q <= cfg_in.id;
        end
    end

    assign cfg = '{enable: enable_q,
                   x_pos: x_pos_q,
                   y_pos: y_pos_q,
                   color: color_q,
                   id: id_q};

endmodule

`default_nettype wire

// ==== text_glyph_lookup.sv ====
// Text overlay glyph stage that fetches the font bit and registers the pixel output
`default_nettype none
`timescale 1ns/10ps

module text_glyph_lookup (
    input  wire logic             pixel_clk,
    input  wire logic             rst_n,
    input  wire text_pkg::locate_t loc,
    output logic                  text_pixel_visible,
    output text_pkg::color_t      text_pixel_color_332
);

    import text_pkg::*;

    glyph_code_t code;
    glyph_bitmap_t bitmap;
    glyph_row_t row_bits;
    glyph_col_idx_t bit_sel;
    logic font_pixel;
    logic visible_d;

    always_comb begin
        code = message_glyph(loc.id, loc.char_idx);   // Space maps to blank
        bitmap = glyph_bitmap(code);
        row_bits = bitmap[CHAR_WIDTH * (CHAR_HEIGHT - 1 - int'(loc.row)) +: CHAR_WIDTH];
        bit_sel = glyph_col_idx_t'(CHAR_WIDTH - 1) - loc.col;    // Leftmost first
        font_pixel = row_bits[bit_sel];
        visible_d = loc.hit && font_pixel;
    end

    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            text_pixel_visible <= 1'b0;
            text_pixel_color_332 <= '0;
        end else begin
            text_pixel_visible <= visible_d;
            text_pixel_color_332 <= visible_d ? loc.color : '0;
        end
    end

endmodule

`default_nettype wire

// ==== text_locator.sv ====
// Text overlay locate stage that finds the character cell under the current pixel
`default_nettype none
`timescale 1ns/10ps

module text_locator (
    input  wire logic             pixel_clk,
    input  wire logic             rst_n,
    input  wire text_pkg::pixel_pos_t pixel,
    input  wire text_pkg::text_cfg_t  cfg,
    output text_pkg::locate_t     loc
);

    import text_pkg::*;

    coord_t rel_x;
    coord_t rel_y;
    coord_t box_width;
    logic hit_d;

    logic hit_q;
    text_id_t id_q;
    color_t color_q;
    char_idx_t char_idx_q;
    glyph_row_idx_t row_q;
    glyph_col_idx_t col_q;

    always_comb begin
        rel_x = pixel.x - cfg.x_pos;
        rel_y = pixel.y - cfg.y_pos;
        box_width = coord_t'(message_length(cfg.id)) * coord_t'(CHAR_WIDTH);
        // Compare on relative offsets so the box clips at the right edge
        hit_d = cfg.enable && pixel.display_enable &&
                (pixel.x >= cfg.x_pos) && (pixel.y >= cfg.y_pos) &&
                (rel_x < box_width) && (rel_y < coord_t'(CHAR_HEIGHT));
    end

    always_ff @(posedge pixel_clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_q <= 1'b0;
        end else begin
            hit_q <= hit_d;
        end
    end

    always_ff @(posedge pixel_clk) begin
        id_q <= cfg.id;
        color_q <= cfg.color;
        char_idx_q <= char_idx_t'(rel_x >> 3);        // Divide by char width
        row_q <= glyph_row_idx_t'(rel_y);
        col_q <= glyph_col_idx_t'(rel_x);
    end

    assign loc = '{hit: hit_q,
                   id: id_q,
                   color: color_q,
                   char_idx: char_idx_q,
                   row: row_q,
                   col: col_q};

endmodule

`default_nettype wire

// ==== text_pkg.sv ====
// Text overlay shared types, message table and 8x16 font bitmaps
`default_nettype none

package text_pkg;

    typedef logic [9:0] coord_t;
    typedef logic [7:0] color_t;              // RGB332
    typedef logic [3:0] text_id_t;
    typedef logic [3:0] char_idx_t;
    typedef logic [3:0] glyph_row_idx_t;
    typedef logic [2:0] glyph_col_idx_t;
    typedef logic [4:0] glyph_code_t;
    typedef logic [7:0] glyph_row_t;          // Leftmost pixel in bit 7
    typedef logic [127:0] glyph_bitmap_t;     // Row 0 in bits 127:120

    localparam int CHAR_WIDTH = 8;
    localparam int CHAR_HEIGHT = 16;
    localparam int MAX_CHARS = 11;            // Longest message

    localparam text_id_t TEXT_MENU = 4'd0;
    localparam text_id_t TEXT_1_PLAYER = 4'd1;
    localparam text_id_t TEXT_2_PLAYER = 4'd2;
    localparam text_id_t TEXT_PRESS_BUTTON = 4'd3;
    localparam text_id_t TEXT_COUNT_3 = 4'd4;
    localparam text_id_t TEXT_COUNT_2 = 4'd5;
    localparam text_id_t TEXT_COUNT_1 = 4'd6;
    localparam text_id_t TEXT_START = 4'd7;

    localparam glyph_code_t G_BLANK = 5'd0;
    localparam glyph_code_t G_M = 5'd1;
    localparam glyph_code_t G_E = 5'd2;
    localparam glyph_code_t G_N = 5'd3;
    localparam glyph_code_t G_U = 5'd4;
    localparam glyph_code_t G_ONE = 5'd5;
    localparam glyph_code_t G_DASH = 5'd6;
    localparam glyph_code_t G_P = 5'd7;
    localparam glyph_code_t G_TWO = 5'd8;
    localparam glyph_code_t G_R = 5'd9;
    localparam glyph_code_t G_S = 5'd10;
    localparam glyph_code_t G_T = 5'd11;
    localparam glyph_code_t G_A = 5'd12;
    localparam glyph_code_t G_CD3 = 5'd13;    // Countdown digits sit one row lower
    localparam glyph_code_t G_CD2 = 5'd14;
    localparam glyph_code_t G_CD1 = 5'd15;

    localparam glyph_bitmap_t FONT_M = 128'hC3E7FFDB_C3C3C3C3_C3C3C3C3_C3C3C300;
    localparam glyph_bitmap_t FONT_E = 128'hFFC0C0C0_FEC0C0C0_C0C0C0C0_C0C0FF00;
    localparam glyph_bitmap_t FONT_N = 128'hC3E3F3FB_DFCFC7C3_C3C3C3C3_C3C3C300;
    localparam glyph_bitmap_t FONT_U = 128'hC3C3C3C3_C3C3C3C3_C3C3C3C3_663C1800;
    localparam glyph_bitmap_t FONT_ONE = 128'h18381818_18181818_18181818_18187E00;
    localparam glyph_bitmap_t FONT_DASH = 128'h00000000_000000FF_FF000000_00000000;
    localparam glyph_bitmap_t FONT_P = 128'hFEC3C3C3_FEC0C0C0_C0C0C0C0_C0C0C000;
    localparam glyph_bitmap_t FONT_TWO = 128'h7EC30303_060C1830_60C0C0C0_C3C3FF00;
    localparam glyph_bitmap_t FONT_R = 128'hFEC3C3C3_FEF8CCC6_C3C3C3C3_C3C3C300;
    localparam glyph_bitmap_t FONT_S = 128'h7EC3C0C0_7E030303_030303C3_7E000000;
    localparam glyph_bitmap_t FONT_T = 128'hFF181818_18181818_18181818_18181800;
    localparam glyph_bitmap_t FONT_A = 128'h3C66C3C3_C3FFC3C3_C3C3C3C3_C3C3C300;
    localparam glyph_bitmap_t FONT_CD3 = 128'h007EC303_033E0303_030303C3_7E000000;
    localparam glyph_bitmap_t FONT_CD2 = 128'h007EC303_060C1830_60C0C3FF_00000000;
    localparam glyph_bitmap_t FONT_CD1 = 128'h00183818_18181818_1818187E_00000000;

    typedef struct packed {
        logic enable;
        coord_t x_pos;                        // Top-left corner
        coord_t y_pos;
        color_t color;
        text_id_t id;
    } text_cfg_t;

    typedef struct packed {
        logic display_enable;
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    typedef struct packed {
        logic hit;
        text_id_t id;
        color_t color;
        char_idx_t char_idx;
        glyph_row_idx_t row;
        glyph_col_idx_t col;
    } locate_t;

    function automatic logic [3:0] message_length(input text_id_t id);
        case (id)
            TEXT_MENU:         return 4'd4;
            TEXT_1_PLAYER:     return 4'd3;
            TEXT_2_PLAYER:     return 4'd3;
            TEXT_PRESS_BUTTON: return 4'd11;
            TEXT_COUNT_3:      return 4'd1;
            TEXT_COUNT_2:      return 4'd1;
            TEXT_COUNT_1:      return 4'd1;
            TEXT_START:        return 4'd5;
            default:           return 4'd0;   // Unused ids draw nothing
        endcase
    endfunction

    function automatic glyph_code_t message_glyph(input text_id_t id, input char_idx_t idx);
        glyph_code_t [0:MAX_CHARS-1] msg;
        case (id)
            TEXT_MENU:         msg = {G_M, G_E, G_N, G_U, {7{G_BLANK}}};
            TEXT_1_PLAYER:     msg = {G_ONE, G_DASH, G_P, {8{G_BLANK}}};
            TEXT_2_PLAYER:     msg = {G_TWO, G_DASH, G_P, {8{G_BLANK}}};
            TEXT_PRESS_BUTTON: msg = {G_P, G_R, G_E, G_S, G_S, G_BLANK,
                                      G_S, G_T, G_A, G_R, G_T};
            TEXT_COUNT_3:      msg = {G_CD3, {10{G_BLANK}}};
            TEXT_COUNT_2:      msg = {G_CD2, {10{G_BLANK}}};
            TEXT_COUNT_1:      msg = {G_CD1, {10{G_BLANK}}};
            TEXT_START:        msg = {G_S, G_T, G_A, G_R, G_T, {6{G_BLANK}}};
            default:           msg = '0;
        endcase
        if (idx < char_idx_t'(MAX_CHARS)) begin
            return msg[idx];
        end
        return G_BLANK;
    endfunction

    function automatic glyph_bitmap_t glyph_bitmap(input glyph_code_t code);
        case (code)
            G_M:     return FONT_M;
            G_E:     return FONT_E;
            G_N:     return FONT_N;
            G_U:     return FONT_U;
            G_ONE:   return FONT_ONE;
            G_DASH:  return FONT_DASH;
            G_P:     return FONT_P;
            G_TWO:   return FONT_TWO;
            G_R:     return FONT_R;
            G_S:     return FONT_S;
            G_T:     return FONT_T;
            G_A:     return FONT_A;
            G_CD3:   return FONT_CD3;
            G_CD2:   return FONT_CD2;
            G_CD1:   return FONT_CD1;
            default: return '0;               // Blank and spare codes
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== text_renderer.f ====
text_pkg.sv
text_cfg_regs.sv
text_locator.sv
text_glyph_lookup.sv
text_renderer.sv
tb_text_renderer.sv

// ==== text_renderer.sv ====
// Text overlay renderer top with config shadow and two-stage pixel pipeline
`default_nettype none
`timescale 1ns/10ps

module text_renderer (
    input  wire logic             pixel_clk,
    input  wire logic             rst_n,
    input  wire text_pkg::pixel_pos_t pixel,
    input  wire logic             frame_start,
    input  wire text_pkg::text_cfg_t  cfg_in,
    output logic                  text_pixel_visible,
    output text_pkg::color_t      text_pixel_color_332
);

    import text_pkg::*;

    text_cfg_t cfg;                   // Frame-stable settings
    locate_t loc;                     // Stage 1 to stage 2

    text_cfg_regs u_cfg_regs (
        .pixel_clk   (pixel_clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .cfg_in      (cfg_in),
        .cfg         (cfg)
    );

    text_locator u_locator (
        .pixel_clk (pixel_clk),
        .rst_n     (rst_n),
        .pixel     (pixel),
        .cfg       (cfg),
        .loc       (loc)
    );

    text_glyph_lookup u_glyph_lookup (
        .pixel_clk            (pixel_clk),
        .rst_n                (rst_n),
        .loc                  (loc),
        .text_pixel_visible   (text_pixel_visible),
        .text_pixel_color_332 (text_pixel_color_332)
    );

endmodule

`default_nettype wire
